//--- rtl/action_select.sv
`timescale 1ns/1ps

module action_select
(
    input  logic                          ace_aclk,
    input  logic                          ace_aresetn,
    input  logic                          i_valid,
    input  logic                          i_pass,
    input  logic [devil_pkg::FUNC_W-1:0]  i_func,
    input  logic                          i_osh_en,
    input  logic                          i_con_en,
    input  logic                          i_shot_done,
    input  logic                          i_busy,
    output logic                          o_valid,
    output logic [devil_pkg::ACT_W-1:0]   o_action,
    output logic                          o_busy
);

    logic [devil_pkg::ACT_W-1:0] action;

    //////////////////////////////////////////////////////////////////////
    // function decode
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        action = devil_pkg::ACT_DUMMY;
        if (i_pass)
        begin
            case (i_func)
                devil_pkg::FUNC_OSH:
                begin
                    // only until the shot has fired once
                    if (i_osh_en && !i_shot_done)
                    begin
                        action = devil_pkg::ACT_ONE_SHOT;
                    end
                end
                devil_pkg::FUNC_CON:
                begin
                    if (i_con_en)
                    begin
                        action = devil_pkg::ACT_CONT;
                    end
                end
                // active paths and data tampering are not on this path
                default:
                begin
                    action = devil_pkg::ACT_DUMMY;
                end
            endcase
        end
    end

    assign o_busy = o_valid || i_busy;

    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge ace_aclk)
    begin
        if (i_valid)
        begin
            o_action <= action;
        end
    end

    // reply engine only takes an action while idle
    a_engine_idle : assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        o_valid |-> !i_busy);

endmodule

//--- rtl/devil_pkg.sv
package devil_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    localparam int ADDR_W      = 44;
    localparam int REG_W       = 32;
    // range filter only looks at the low word of the address
    localparam int FILT_ADDR_W = 32;
    localparam int SNOOP_W     = 4;
    localparam int CRRESP_W    = 5;

    //////////////////////////////////////////////////////////////////////
    // control register layout
    //////////////////////////////////////////////////////////////////////

    localparam int CTRL_EN         = 0;
    localparam int CTRL_TEST_LSB   = 1;
    localparam int CTRL_FUNC_LSB   = 5;
    localparam int CTRL_CRRESP_LSB = 9;
    localparam int CTRL_ACF        = 14;
    localparam int CTRL_ADDRF      = 15;
    localparam int CTRL_OSH_EN     = 16;
    localparam int CTRL_CON_EN     = 17;

    // function field
    localparam int FUNC_W = 4;
    localparam logic [FUNC_W-1:0] FUNC_OSH = 4'd1;
    localparam logic [FUNC_W-1:0] FUNC_CON = 4'd2;
    localparam logic [FUNC_W-1:0] FUNC_ADL = 4'd3;
    localparam logic [FUNC_W-1:0] FUNC_ADT = 4'd4;
    localparam logic [FUNC_W-1:0] FUNC_PDT = 4'd5;

    // test field, any other code raises no strobe
    localparam int TEST_W = 4;
    localparam logic [TEST_W-1:0] TEST_FUZZ        = 4'd1;
    localparam logic [TEST_W-1:0] TEST_DLY_CRVALID = 4'd2;
    localparam logic [TEST_W-1:0] TEST_DLY_CDVALID = 4'd3;
    localparam logic [TEST_W-1:0] TEST_DLY_CDLAST  = 4'd4;

    //////////////////////////////////////////////////////////////////////
    // reply actions and delay
    //////////////////////////////////////////////////////////////////////

    localparam int ACT_W = 2;
    localparam logic [ACT_W-1:0] ACT_DUMMY    = 2'd0;
    localparam logic [ACT_W-1:0] ACT_ONE_SHOT = 2'd1;
    localparam logic [ACT_W-1:0] ACT_CONT     = 2'd2;

    localparam int DELAY_SEL_W = 4;
    localparam int DELAY_CNT_W = 32;
    // base delay, shifted by selector-1
    localparam logic [DELAY_CNT_W-1:0] DELAY_UNIT = 32'd16;

    // reply engine states
    localparam int ST_W = 3;
    localparam logic [ST_W-1:0] ST_IDLE  = 3'd0;
    localparam logic [ST_W-1:0] ST_WAIT  = 3'd1;
    localparam logic [ST_W-1:0] ST_DUMMY = 3'd2;
    localparam logic [ST_W-1:0] ST_RESP  = 3'd3;
    localparam logic [ST_W-1:0] ST_DELAY = 3'd4;
    localparam logic [ST_W-1:0] ST_END   = 3'd5;

endpackage

//--- rtl/passive_devil.sv
`timescale 1ns/1ps

module passive_devil
(
    input  logic                              ace_aclk,
    input  logic                              ace_aresetn,
    input  logic                              i_trigger,
    input  logic [devil_pkg::SNOOP_W-1:0]     i_acsnoop_snapshot,
    input  logic [devil_pkg::ADDR_W-1:0]      i_acaddr_snapshot,
    input  logic [devil_pkg::REG_W-1:0]       i_control_reg,
    input  logic [devil_pkg::REG_W-1:0]       i_acsnoop_reg,
    input  logic [devil_pkg::REG_W-1:0]       i_base_addr_reg,
    input  logic [devil_pkg::REG_W-1:0]       i_addr_size_reg,
    input  logic [devil_pkg::DELAY_SEL_W-1:0] i_delay_sel,
    input  logic                              i_crready,
    output logic [devil_pkg::CRRESP_W-1:0]    o_crresp,
    output logic                              o_crvalid,
    output logic                              o_cdvalid,
    output logic                              o_cdlast,
    output logic                              o_reply,
    output logic                              o_end,
    output logic                              o_busy
);

    logic                             f_valid;
    logic                             f_pass;
    logic                             a_valid;
    logic [devil_pkg::ACT_W-1:0]      a_action;
    logic                             a_busy;
    logic                             e_busy;
    logic [devil_pkg::TEST_W-1:0]     ctrl_test;
    logic [devil_pkg::FUNC_W-1:0]     ctrl_func;
    logic [devil_pkg::CRRESP_W-1:0]   ctrl_crresp;

    // control register fields
    assign ctrl_test   = i_control_reg[devil_pkg::CTRL_TEST_LSB +: devil_pkg::TEST_W];
    assign ctrl_func   = i_control_reg[devil_pkg::CTRL_FUNC_LSB +: devil_pkg::FUNC_W];
    assign ctrl_crresp = i_control_reg[devil_pkg::CTRL_CRRESP_LSB +: devil_pkg::CRRESP_W];

    snoop_filter u_filter
    (
        .ace_aclk           (ace_aclk),
        .ace_aresetn        (ace_aresetn),
        .i_trigger          (i_trigger),
        .i_acsnoop_snapshot (i_acsnoop_snapshot),
        .i_acaddr_snapshot  (i_acaddr_snapshot),
        .i_acsnoop_reg      (i_acsnoop_reg),
        .i_base_addr_reg    (i_base_addr_reg),
        .i_addr_size_reg    (i_addr_size_reg),
        .i_ac_filter_en     (i_control_reg[devil_pkg::CTRL_ACF]),
        .i_addr_filter_en   (i_control_reg[devil_pkg::CTRL_ADDRF]),
        .i_busy             (a_busy),
        .o_valid            (f_valid),
        .o_pass             (f_pass),
        .o_busy             (o_busy)
    );

    // end flag feeds back so a fired one-shot turns into dummy replies
    action_select u_action
    (
        .ace_aclk    (ace_aclk),
        .ace_aresetn (ace_aresetn),
        .i_valid     (f_valid),
        .i_pass      (f_pass),
        .i_func      (ctrl_func),
        .i_osh_en    (i_control_reg[devil_pkg::CTRL_OSH_EN]),
        .i_con_en    (i_control_reg[devil_pkg::CTRL_CON_EN]),
        .i_shot_done (o_end),
        .i_busy      (e_busy),
        .o_valid     (a_valid),
        .o_action    (a_action),
        .o_busy      (a_busy)
    );

    reply_engine u_engine
    (
        .ace_aclk    (ace_aclk),
        .ace_aresetn (ace_aresetn),
        .i_valid     (a_valid),
        .i_action    (a_action),
        .i_crready   (i_crready),
        .i_test      (ctrl_test),
        .i_crresp    (ctrl_crresp),
        .i_delay_sel (i_delay_sel),
        .i_en        (i_control_reg[devil_pkg::CTRL_EN]),
        .o_crresp    (o_crresp),
        .o_crvalid   (o_crvalid),
        .o_cdvalid   (o_cdvalid),
        .o_cdlast    (o_cdlast),
        .o_reply     (o_reply),
        .o_end       (o_end),
        .o_busy      (e_busy)
    );

endmodule

//--- rtl/reply_engine.sv
`timescale 1ns/1ps

module reply_engine
(
    input  logic                              ace_aclk,
    input  logic                              ace_aresetn,
    input  logic                              i_valid,
    input  logic [devil_pkg::ACT_W-1:0]       i_action,
    input  logic                              i_crready,
    input  logic [devil_pkg::TEST_W-1:0]      i_test,
    input  logic [devil_pkg::CRRESP_W-1:0]    i_crresp,
    input  logic [devil_pkg::DELAY_SEL_W-1:0] i_delay_sel,
    input  logic                              i_en,
    output logic [devil_pkg::CRRESP_W-1:0]    o_crresp,
    output logic                              o_crvalid,
    output logic                              o_cdvalid,
    output logic                              o_cdlast,
    output logic                              o_reply,
    output logic                              o_end,
    output logic                              o_busy
);

    logic [devil_pkg::ST_W-1:0]        state;
    logic [devil_pkg::ACT_W-1:0]       action_q;
    logic [devil_pkg::DELAY_CNT_W-1:0] delay_cnt;
    logic [devil_pkg::DELAY_CNT_W-1:0] delay_len;
    logic                              tamper;
    logic                              one_shot;

    // selector 0 means no extra wait
    assign delay_len = (i_delay_sel == '0) ? '0 :
                       (devil_pkg::DELAY_UNIT << (i_delay_sel - 1'b1));

    assign tamper   = (action_q != devil_pkg::ACT_DUMMY);
    assign one_shot = (action_q == devil_pkg::ACT_ONE_SHOT);

    // reply pulse is the single cycle spent in the end state
    assign o_reply = (state == devil_pkg::ST_END);
    assign o_busy  = (state != devil_pkg::ST_IDLE);

    //////////////////////////////////////////////////////////////////////
    // reply FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            state     <= devil_pkg::ST_IDLE;
            o_crresp  <= '0;
            o_crvalid <= 1'b0;
            o_cdvalid <= 1'b0;
            o_cdlast  <= 1'b0;
            o_end     <= 1'b0;
        end
        else
        begin
            case (state)
                devil_pkg::ST_IDLE:
                begin
                    if (i_valid)
                    begin
                        action_q <= i_action;
                        state    <= devil_pkg::ST_WAIT;
                    end
                    // end flag is only released by clearing the enable bit
                    if (!i_en)
                    begin
                        o_end <= 1'b0;
                    end
                end
                devil_pkg::ST_WAIT:
                begin
                    if (i_crready && !tamper)
                    begin
                        o_crresp  <= '0;
                        o_crvalid <= 1'b1;
                        state     <= devil_pkg::ST_DUMMY;
                    end
                    else if (i_crready)
                    begin
                        o_crresp  <= i_crresp;
                        delay_cnt <= '0;
                        case (i_test)
                            devil_pkg::TEST_FUZZ:
                            begin
                                o_crvalid <= 1'b1;
                                o_cdvalid <= 1'b1;
                                o_cdlast  <= 1'b1;
                                state     <= devil_pkg::ST_RESP;
                            end
                            devil_pkg::TEST_DLY_CRVALID:
                            begin
                                o_cdvalid <= 1'b1;
                                o_cdlast  <= 1'b1;
                                state     <= devil_pkg::ST_DELAY;
                            end
                            devil_pkg::TEST_DLY_CDVALID:
                            begin
                                o_crvalid <= 1'b1;
                                o_cdlast  <= 1'b1;
                                state     <= devil_pkg::ST_DELAY;
                            end
                            devil_pkg::TEST_DLY_CDLAST:
                            begin
                                o_crvalid <= 1'b1;
                                o_cdvalid <= 1'b1;
                                state     <= devil_pkg::ST_DELAY;
                            end
                            default:
                            begin
                                // no strobe, straight to the ending
                                o_end <= o_end || one_shot;
                                state <= devil_pkg::ST_END;
                            end
                        endcase
                    end
                end
                devil_pkg::ST_DUMMY:
                begin
                    o_crvalid <= 1'b0;
                    state     <= devil_pkg::ST_END;
                end
                devil_pkg::ST_DELAY:
                begin
                    if (delay_cnt == delay_len)
                    begin
                        // other two strobes are already up
                        o_crvalid <= 1'b1;
                        o_cdvalid <= 1'b1;
                        o_cdlast  <= 1'b1;
                        state     <= devil_pkg::ST_RESP;
                    end
                    else
                    begin
                        delay_cnt <= delay_cnt + 1'b1;
                    end
                end
                devil_pkg::ST_RESP:
                begin
                    o_crvalid <= 1'b0;
                    o_cdvalid <= 1'b0;
                    o_cdlast  <= 1'b0;
                    o_end     <= o_end || one_shot;
                    state     <= devil_pkg::ST_END;
                end
                devil_pkg::ST_END:
                begin
                    o_crresp <= '0;
                    state    <= devil_pkg::ST_IDLE;
                end
                default:
                begin
                    state <= devil_pkg::ST_IDLE;
                end
            endcase
        end
    end

    a_idle_quiet : assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        (state == devil_pkg::ST_IDLE) |-> !(o_crvalid || o_cdvalid || o_cdlast));

    // strobes are all down by the time the reply pulses
    a_reply_quiet : assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        o_reply |-> !(o_crvalid || o_cdvalid || o_cdlast));

endmodule

//--- rtl/snoop_filter.sv
`timescale 1ns/1ps

module snoop_filter
(
    input  logic                             ace_aclk,
    input  logic                             ace_aresetn,
    input  logic                             i_trigger,
    input  logic [devil_pkg::SNOOP_W-1:0]    i_acsnoop_snapshot,
    input  logic [devil_pkg::ADDR_W-1:0]     i_acaddr_snapshot,
    input  logic [devil_pkg::REG_W-1:0]      i_acsnoop_reg,
    input  logic [devil_pkg::REG_W-1:0]      i_base_addr_reg,
    input  logic [devil_pkg::REG_W-1:0]      i_addr_size_reg,
    input  logic                             i_ac_filter_en,
    input  logic                             i_addr_filter_en,
    input  logic                             i_busy,
    output logic                             o_valid,
    output logic                             o_pass,
    output logic                             o_busy
);

    logic [devil_pkg::FILT_ADDR_W-1:0] addr_lo;
    logic [devil_pkg::FILT_ADDR_W-1:0] base_lo;
    logic [devil_pkg::FILT_ADDR_W-1:0] limit_lo;
    logic                              ac_match;
    logic                              addr_match;
    logic                              pass;
    logic                              accept;

    // range check on the low address word only
    assign addr_lo    = i_acaddr_snapshot[devil_pkg::FILT_ADDR_W-1:0];
    assign base_lo    = i_base_addr_reg[devil_pkg::FILT_ADDR_W-1:0];
    assign limit_lo   = base_lo + i_addr_size_reg[devil_pkg::FILT_ADDR_W-1:0];
    assign addr_match = (addr_lo >= base_lo) && (addr_lo < limit_lo);

    assign ac_match = (i_acsnoop_snapshot == i_acsnoop_reg[devil_pkg::SNOOP_W-1:0]);

    // a disabled filter lets every snoop through
    assign pass = (ac_match || !i_ac_filter_en) && (addr_match || !i_addr_filter_en);

    // one snoop in flight, later triggers are dropped
    assign accept = i_trigger && !o_busy;
    assign o_busy = o_valid || i_busy;

    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= accept;
        end
    end

    // verdict from the snapshot taken with the trigger
    always_ff @(posedge ace_aclk)
    begin
        if (accept)
        begin
            o_pass <= pass;
        end
    end

    // later stages are drained when a new verdict leaves
    a_stages_empty : assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        o_valid |-> !i_busy);

endmodule

//--- run.sh
#!/bin/sh
# build and run the passive_devil testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_passive_devil -f verilog.f -o sim_tb

out=$(./obj_dir/sim_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "NO ERRORS"
then
    exit 0
fi
exit 1

//--- test/tb_passive_devil.sv
`timescale 1ns/1ps

module tb_passive_devil;

    localparam int N_SNOOPS = 150;
    localparam int TIMEOUT  = 200;

    logic                              ace_aclk;
    logic                              ace_aresetn;
    logic                              trigger;
    logic [devil_pkg::SNOOP_W-1:0]     acsnoop_snap;
    logic [devil_pkg::ADDR_W-1:0]      acaddr_snap;
    logic [devil_pkg::REG_W-1:0]       control_reg;
    logic [devil_pkg::REG_W-1:0]       acsnoop_reg;
    logic [devil_pkg::REG_W-1:0]       base_reg;
    logic [devil_pkg::REG_W-1:0]       size_reg;
    logic [devil_pkg::DELAY_SEL_W-1:0] delay_sel;
    logic                              crready;
    logic [devil_pkg::CRRESP_W-1:0]    crresp;
    logic                              crvalid;
    logic                              cdvalid;
    logic                              cdlast;
    logic                              reply;
    logic                              end_flag;
    logic                              busy;

    integer seed;
    int     errors;
    int     replies = 0;
    logic   exp_end;
    logic   prev_en;
    logic   stuck;

    passive_devil UUT
    (
        .ace_aclk           (ace_aclk),
        .ace_aresetn        (ace_aresetn),
        .i_trigger          (trigger),
        .i_acsnoop_snapshot (acsnoop_snap),
        .i_acaddr_snapshot  (acaddr_snap),
        .i_control_reg      (control_reg),
        .i_acsnoop_reg      (acsnoop_reg),
        .i_base_addr_reg    (base_reg),
        .i_addr_size_reg    (size_reg),
        .i_delay_sel        (delay_sel),
        .i_crready          (crready),
        .o_crresp           (crresp),
        .o_crvalid          (crvalid),
        .o_cdvalid          (cdvalid),
        .o_cdlast           (cdlast),
        .o_reply            (reply),
        .o_end              (end_flag),
        .o_busy             (busy)
    );

    initial ace_aclk = 1'b0;
    always #50 ace_aclk = ~ace_aclk;

    // every reply pulse seen, so an extra one shows up in the count
    always @(negedge ace_aclk)
    begin
        if (ace_aresetn && reply)
        begin
            replies <= replies + 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    function automatic int unsigned rand_below(input int unsigned lim);
        int unsigned r;
        r = $random(seed);
        return r % lim;
    endfunction

    // the strobe that a delay mode holds back
    function automatic logic delayed_strobe(input logic [devil_pkg::TEST_W-1:0] test);
        case (test)
            devil_pkg::TEST_DLY_CRVALID: return crvalid;
            devil_pkg::TEST_DLY_CDVALID: return cdvalid;
            default:                     return cdlast;
        endcase
    endfunction

    task automatic compare_bit(input string name, input logic exp, input logic got);
        if (exp !== got)
        begin
            $display("ERR %0t %s expected %0b actual %0b", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic compare_resp(input logic [devil_pkg::CRRESP_W-1:0] exp);
        if (exp !== crresp)
        begin
            $display("ERR %0t o_crresp expected %0h actual %0h", $time, exp, crresp);
            errors++;
        end
    endtask

    task automatic check_outputs(input logic crv, input logic cdv, input logic cdl,
                                 input logic rep);
        compare_bit("o_crvalid", crv, crvalid);
        compare_bit("o_cdvalid", cdv, cdvalid);
        compare_bit("o_cdlast", cdl, cdlast);
        compare_bit("o_reply", rep, reply);
    endtask

    task automatic wait_idle;
        int n;
        n = 0;
        @(negedge ace_aclk);
        while (busy && n < TIMEOUT)
        begin
            @(negedge ace_aclk);
            n++;
        end
        if (busy)
        begin
            $display("timeout: busy stayed high for %0d cycles", TIMEOUT);
            errors++;
            stuck = 1'b1;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // one snoop, from trigger to idle
    //////////////////////////////////////////////////////////////////////

    task automatic run_snoop;
        logic                              en;
        logic                              acf;
        logic                              addrf;
        logic                              osh_en;
        logic                              con_en;
        logic                              pass;
        logic [devil_pkg::TEST_W-1:0]      test;
        logic [devil_pkg::FUNC_W-1:0]      func;
        logic [devil_pkg::CRRESP_W-1:0]    code;
        logic [devil_pkg::SNOOP_W-1:0]     snap;
        logic [31:0]                       snoop_reg;
        logic [31:0]                       ctrl;
        logic [31:0]                       base;
        logic [31:0]                       size;
        logic [31:0]                       addr_lo;
        logic [devil_pkg::DELAY_SEL_W-1:0] sel;
        logic [devil_pkg::ACT_W-1:0]       act;
        int                                bp;
        int                                n;
        int                                n_exp;
        int                                replies_before;

        en        = (rand_below(6) != 0);
        acf       = 1'(rand_below(2));
        addrf     = 1'(rand_below(2));
        osh_en    = (rand_below(4) != 0);
        con_en    = (rand_below(4) != 0);
        test      = 4'(rand_below(6));
        func      = 4'(rand_below(7));
        code      = 5'(rand_below(31) + 1);
        sel       = 4'(rand_below(4));
        snoop_reg = $random(seed);
        snap      = (rand_below(2) == 0) ? snoop_reg[3:0] : 4'(rand_below(16));
        // base kept clear of wraparound, address lands just around the window
        base      = rand_below(32'h4000_0000) + 32'h1000;
        size      = rand_below(256);
        addr_lo   = base + rand_below(384) - 32'd64;
        bp        = int'(rand_below(6));

        ctrl = '0;
        ctrl[devil_pkg::CTRL_EN] = en;
        ctrl[devil_pkg::CTRL_TEST_LSB +: devil_pkg::TEST_W] = test;
        ctrl[devil_pkg::CTRL_FUNC_LSB +: devil_pkg::FUNC_W] = func;
        ctrl[devil_pkg::CTRL_CRRESP_LSB +: devil_pkg::CRRESP_W] = code;
        ctrl[devil_pkg::CTRL_ACF] = acf;
        ctrl[devil_pkg::CTRL_ADDRF] = addrf;
        ctrl[devil_pkg::CTRL_OSH_EN] = osh_en;
        ctrl[devil_pkg::CTRL_CON_EN] = con_en;

        // reference model of filter, end flag and action choice
        pass = (snap == snoop_reg[3:0] || !acf)
            && ((addr_lo >= base && addr_lo < base + size) || !addrf);
        if (!prev_en || !en)
        begin
            exp_end = 1'b0;
        end
        act = devil_pkg::ACT_DUMMY;
        if (pass && func == devil_pkg::FUNC_OSH && osh_en && !exp_end)
        begin
            act = devil_pkg::ACT_ONE_SHOT;
        end
        if (pass && func == devil_pkg::FUNC_CON && con_en)
        begin
            act = devil_pkg::ACT_CONT;
        end
        n_exp = (sel == 0) ? 1 : (16 << (sel - 1)) + 1;
        replies_before = replies;

        @(posedge ace_aclk);
        trigger      <= 1'b1;
        control_reg  <= ctrl;
        acsnoop_reg  <= snoop_reg;
        acsnoop_snap <= snap;
        base_reg     <= base;
        size_reg     <= size;
        acaddr_snap  <= {12'(rand_below(4096)), addr_lo};
        delay_sel    <= sel;
        crready      <= 1'b0;
        @(posedge ace_aclk);
        // sometimes hold the trigger into the busy cycle
        trigger <= 1'(rand_below(2));
        @(negedge ace_aclk);
        compare_bit("o_busy", 1'b1, busy);
        compare_bit("o_end", exp_end, end_flag);
        @(posedge ace_aclk);
        trigger <= 1'b0;
        @(posedge ace_aclk);
        // engine now waits, back-pressure keeps it quiet
        for (n = 0; n < bp; n++)
        begin
            @(negedge ace_aclk);
            check_outputs(1'b0, 1'b0, 1'b0, 1'b0);
            @(posedge ace_aclk);
        end
        crready <= 1'b1;
        @(posedge ace_aclk);
        crready <= 1'(rand_below(2));
        @(negedge ace_aclk);

        if (act == devil_pkg::ACT_DUMMY)
        begin
            check_outputs(1'b1, 1'b0, 1'b0, 1'b0);
            compare_resp('0);
            @(negedge ace_aclk);
        end
        else
        begin
            compare_resp(code);
            if (test == devil_pkg::TEST_FUZZ)
            begin
                check_outputs(1'b1, 1'b1, 1'b1, 1'b0);
                @(negedge ace_aclk);
            end
            else if (test >= devil_pkg::TEST_DLY_CRVALID && test <= devil_pkg::TEST_DLY_CDLAST)
            begin
                check_outputs(test != devil_pkg::TEST_DLY_CRVALID,
                              test != devil_pkg::TEST_DLY_CDVALID,
                              test != devil_pkg::TEST_DLY_CDLAST, 1'b0);
                n = 0;
                while (!delayed_strobe(test) && n < TIMEOUT)
                begin
                    @(negedge ace_aclk);
                    n++;
                end
                if (!delayed_strobe(test))
                begin
                    $display("timeout: delayed strobe never rose in test mode %0d", test);
                    errors++;
                    stuck = 1'b1;
                    return;
                end
                if (n != n_exp)
                begin
                    $display("ERR %0t delayed strobe cycles expected %0d actual %0d",
                             $time, n_exp, n);
                    errors++;
                end
                check_outputs(1'b1, 1'b1, 1'b1, 1'b0);
                @(negedge ace_aclk);
            end
            if (act == devil_pkg::ACT_ONE_SHOT)
            begin
                exp_end = 1'b1;
            end
        end

        // ending, then back to idle
        check_outputs(1'b0, 1'b0, 1'b0, 1'b1);
        compare_bit("o_end", exp_end, end_flag);
        @(negedge ace_aclk);
        compare_bit("o_reply", 1'b0, reply);
        compare_bit("o_busy", 1'b0, busy);
        if (replies != replies_before + 1)
        begin
            $display("ERR %0t reply count expected %0d actual %0d",
                     $time, replies_before + 1, replies);
            errors++;
        end
        prev_en = en;
    endtask

    initial
    begin
        seed    = 32'hb885;
        errors  = 0;
        stuck   = 1'b0;
        exp_end = 1'b0;
        prev_en = 1'b0;
        ace_aresetn  <= 1'b0;
        trigger      <= 1'b0;
        acsnoop_snap <= '0;
        acaddr_snap  <= '0;
        control_reg  <= '0;
        acsnoop_reg  <= '0;
        base_reg     <= '0;
        size_reg     <= '0;
        delay_sel    <= '0;
        crready      <= 1'b0;
        repeat (3) @(posedge ace_aclk);
        ace_aresetn <= 1'b1;
        @(negedge ace_aclk);
        check_outputs(1'b0, 1'b0, 1'b0, 1'b0);
        compare_bit("o_end", 1'b0, end_flag);
        compare_bit("o_busy", 1'b0, busy);

        for (int i = 0; i < N_SNOOPS && !stuck; i++)
        begin
            wait_idle();
            if (!stuck)
            begin
                run_snoop();
            end
        end

        $display("errors: %0d", errors);
        if (errors == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- verilog.f
rtl/devil_pkg.sv
rtl/snoop_filter.sv
rtl/action_select.sv
rtl/reply_engine.sv
rtl/passive_devil.sv
test/tb_passive_devil.sv
